//--- common/dotk_defines.svh
`ifndef DOTK_DEFINES_SVH
`define DOTK_DEFINES_SVH

// datapath widths
// sample and coefficient word
`define DATA_W 16
// 24 products of 16x16 fit well inside 40 bits
`define ACC_W 40

// buffer geometry
`define ADDR_W 10
`define MEM_DEPTH 1024

// loop structure of one run
// outer loop, blocks per run
`define K_ITER 4
// inner loop, reads per block
`define J_LEN 24
// address step between block starts
`define I_STRIDE 128

`endif

//--- common/dotk_pkg.sv
`include "dotk_defines.svh"

package dotk_pkg;

    // payload types
    // one buffer word
    typedef logic [`DATA_W-1:0] data_t;
    // one block sum
    typedef logic [`ACC_W-1:0] acc_t;
    // buffer address, shared by host and sequencer
    typedef logic [`ADDR_W-1:0] addr_t;

    // output drain FSM
    typedef enum logic [1:0] {
        // nothing held, ready to capture
        drain_idle,
        // sum offered on res_data
        drain_hold,
        // final sum of the run gone, out_fin high
        drain_last
    } drain_state_e;

endpackage

//--- exe/agu_next.sv
`timescale 1ns/1ps
`default_nettype none

module agu_next #(
    parameter int W   = 4,
    parameter int INI = 0,
    parameter int FIN = 3
) (
    input  wire logic   clk,
    input  wire logic   rst,
    input  wire logic   start,
    input  wire logic   en,
    output logic [W-1:0] data,
    output logic         next,
    output logic         last
);

    logic armed;
    logic step;

    // counts only between start and the terminal step
    assign step = armed & en;
    assign last = step & (data == W'(FIN));
    assign next = step & (data != W'(FIN));

    always_ff @(posedge clk) begin
        if (rst) begin
            armed <= 1'b0;
            data  <= W'(INI);
        end else if (start) begin
            armed <= 1'b1;
            data  <= W'(INI);
        end else if (last) begin
            // hold the end value once done
            armed <= 1'b0;
        end else if (next) begin
            data <= data + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- exe/exe_ctrl.sv
`timescale 1ns/1ps
`default_nettype none
`include "dotk_defines.svh"

module exe_ctrl (
    input  wire logic          clk,
    input  wire logic          rst,
    input  wire logic          s_init,
    input  wire logic          out_busy,
    input  wire logic          out_fin,
    output logic               s_fin,
    output logic               k_init,
    output logic               k_fin,
    output logic               exec,
    output dotk_pkg::addr_t    exec_src_addr
);

    // counter widths, one spare bit keeps $clog2 nonzero
    localparam int I_W = $clog2(`K_ITER + 1);
    localparam int J_W = $clog2(`J_LEN + 1);

    logic [I_W-1:0] i_cnt;
    logic [J_W-1:0] j_cnt;
    logic           next_i;
    logic           last_i;
    logic           last_j;
    logic           s_init_d;
    logic           blk_d1;
    logic           blk_d2;
    logic           blk_d3;
    logic           blk_pend;
    logic           fin_win;

    //////////////////////////////////////////////////
    // block start
    //////////////////////////////////////////////////

    // run start seen one cycle late
    always_ff @(posedge clk) begin
        if (rst) begin
            s_init_d <= 1'b0;
        end else begin
            s_init_d <= s_init;
        end
    end

    // next block request, two cycles behind k_fin
    always_ff @(posedge clk) begin
        if (rst) begin
            blk_d1 <= 1'b0;
            blk_d2 <= 1'b0;
            blk_d3 <= 1'b0;
        end else begin
            blk_d1 <= next_i;
            blk_d2 <= blk_d1;
            blk_d3 <= blk_d2;
        end
    end

    // request parked here while the drain is busy
    always_ff @(posedge clk) begin
        if (rst) begin
            blk_pend <= 1'b0;
        end else if (k_init) begin
            blk_pend <= 1'b0;
        end else if (s_init_d || blk_d3) begin
            blk_pend <= 1'b1;
        end
    end

    // fire as soon as the held sum has left
    assign k_init = (s_init_d | blk_d3 | blk_pend) & ~out_busy;

    //////////////////////////////////////////////////
    // inner loop and exec window
    //////////////////////////////////////////////////

    // high from the cycle after k_init up to the inner terminal count
    always_ff @(posedge clk) begin
        if (rst) begin
            exec  <= 1'b0;
            k_fin <= 1'b0;
        end else begin
            exec  <= k_init | (exec & ~last_j);
            k_fin <= last_j;
        end
    end

    // outer loop, steps once per block
    agu_next #(.W(I_W), .INI(0), .FIN(`K_ITER - 1)) l_i (
        .clk(clk), .rst(rst), .start(s_init_d), .en(last_j),
        .data(i_cnt), .next(next_i), .last(last_i)
    );

    // inner loop, loaded by k_init so j is 0 in the first exec cycle
    agu_next #(.W(J_W), .INI(0), .FIN(`J_LEN - 1)) l_j (
        .clk(clk), .rst(rst), .start(k_init), .en(1'b1),
        .data(j_cnt), .next(), .last(last_j)
    );

    // block base plus inner offset
    assign exec_src_addr = dotk_pkg::addr_t'(i_cnt * `I_STRIDE + j_cnt);

    //////////////////////////////////////////////////
    // end of run
    //////////////////////////////////////////////////

    // open after the last block, wait for the drain to empty
    always_ff @(posedge clk) begin
        if (rst) begin
            fin_win <= 1'b0;
        end else if (last_i) begin
            fin_win <= 1'b1;
        end else if (out_fin) begin
            fin_win <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            s_fin <= 1'b0;
        end else begin
            s_fin <= fin_win & out_fin;
        end
    end

endmodule

`default_nettype wire

//--- logic/src_buff.sv
`timescale 1ns/1ps
`default_nettype none
`include "dotk_defines.svh"

module src_buff (
    input  wire logic             clk,
    input  wire logic             we,
    input  wire dotk_pkg::addr_t  waddr,
    input  wire dotk_pkg::data_t  wdata,
    input  wire dotk_pkg::addr_t  raddr,
    output dotk_pkg::data_t       rd_data
);

    // source samples, one word per address
    dotk_pkg::data_t mem [`MEM_DEPTH];

    //////////////////////////////////////////////////
    // host write port
    //////////////////////////////////////////////////

    // only during loading, never while a run reads
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    //////////////////////////////////////////////////
    // sequencer read port
    //////////////////////////////////////////////////

    // registered read
    // data lines up with the delayed exec in mac_lane
    always_ff @(posedge clk) begin
        rd_data <= mem[raddr];
    end

endmodule

`default_nettype wire

//--- logic/coef_buff.sv
`timescale 1ns/1ps
`default_nettype none
`include "dotk_defines.svh"

module coef_buff (
    input  wire logic             clk,
    input  wire logic             we,
    input  wire dotk_pkg::addr_t  waddr,
    input  wire dotk_pkg::data_t  wdata,
    input  wire dotk_pkg::addr_t  raddr,
    output dotk_pkg::data_t       rd_data
);

    // coefficients, same layout as the source buffer
    dotk_pkg::data_t mem [`MEM_DEPTH];

    //////////////////////////////////////////////////
    // host write port
    //////////////////////////////////////////////////

    // we already qualified by the select bit
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    //////////////////////////////////////////////////
    // sequencer read port
    //////////////////////////////////////////////////

    // same address as src_buff in the same cycle
    // so both words arrive together
    always_ff @(posedge clk) begin
        rd_data <= mem[raddr];
    end

endmodule

`default_nettype wire

//--- logic/mac_lane.sv
`timescale 1ns/1ps
`default_nettype none

module mac_lane (
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire logic             k_init,
    input  wire logic             exec,
    input  wire logic             k_fin,
    input  wire dotk_pkg::data_t  src_data,
    input  wire dotk_pkg::data_t  coef_data,
    output logic                  sum_valid,
    output dotk_pkg::acc_t        sum_data
);

    logic           exec_d;
    dotk_pkg::acc_t acc;

    //////////////////////////////////////////////////
    // read latency alignment
    //////////////////////////////////////////////////

    // buffers answer one cycle after the address
    always_ff @(posedge clk) begin
        if (rst) begin
            exec_d <= 1'b0;
        end else begin
            exec_d <= exec;
        end
    end

    // delayed k_fin doubles as the sum strobe
    // one cycle after k_fin the last product is in acc
    always_ff @(posedge clk) begin
        if (rst) begin
            sum_valid <= 1'b0;
        end else begin
            sum_valid <= k_fin;
        end
    end

    //////////////////////////////////////////////////
    // accumulator
    //////////////////////////////////////////////////

    // cleared at each block start
    // unsigned product, acc width leaves headroom
    always_ff @(posedge clk) begin
        if (k_init) begin
            acc <= '0;
        end else if (exec_d) begin
            acc <= acc + src_data * coef_data;
        end
    end

    // acc holds the block sum until the next k_init,
    // which cannot come before the drain has captured it
    assign sum_data = acc;

endmodule

`default_nettype wire

//--- logic/out_drain.sv
`timescale 1ns/1ps
`default_nettype none
`include "dotk_defines.svh"

module out_drain (
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire logic             sum_valid,
    input  wire dotk_pkg::acc_t   sum_data,
    input  wire logic             res_stall,
    output logic                  res_valid,
    output dotk_pkg::acc_t        res_data,
    output logic                  out_busy,
    output logic                  out_fin
);

    localparam int C_W = $clog2(`K_ITER + 1);

    dotk_pkg::drain_state_e state;
    logic [C_W-1:0]         taken_cnt;
    logic                   taken;

    // result leaves when offered and not stalled
    assign taken = (state == dotk_pkg::drain_hold) & ~res_stall;

    //////////////////////////////////////////////////
    // drain FSM
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= dotk_pkg::drain_idle;
            taken_cnt <= '0;
        end else begin
            case (state)
                dotk_pkg::drain_idle: begin
                    if (sum_valid) begin
                        state <= dotk_pkg::drain_hold;
                    end
                end
                dotk_pkg::drain_hold: begin
                    // last block of the run, restart the count
                    if (taken && taken_cnt == C_W'(`K_ITER - 1)) begin
                        state     <= dotk_pkg::drain_last;
                        taken_cnt <= '0;
                    end else if (taken) begin
                        state     <= dotk_pkg::drain_idle;
                        taken_cnt <= taken_cnt + 1'b1;
                    end
                end
                default: begin
                    state <= dotk_pkg::drain_idle;
                end
            endcase
        end
    end

    // capture only when empty
    always_ff @(posedge clk) begin
        if (state == dotk_pkg::drain_idle && sum_valid) begin
            res_data <= sum_data;
        end
    end

    // outputs straight from the state
    assign res_valid = (state == dotk_pkg::drain_hold);
    assign out_busy  = (state != dotk_pkg::drain_idle);
    assign out_fin   = (state == dotk_pkg::drain_last);

endmodule

`default_nettype wire

//--- logic/dotk_top.sv
`timescale 1ns/1ps
`default_nettype none

module dotk_top (
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire logic             ld_we,
    input  wire logic             ld_sel,
    input  wire dotk_pkg::addr_t  ld_addr,
    input  wire dotk_pkg::data_t  ld_data,
    input  wire logic             s_init,
    input  wire logic             res_stall,
    output logic                  res_valid,
    output dotk_pkg::acc_t        res_data,
    output logic                  s_fin
);

    logic            k_init;
    logic            k_fin;
    logic            exec;
    logic            out_busy;
    logic            out_fin;
    logic            sum_valid;
    dotk_pkg::addr_t exec_src_addr;
    dotk_pkg::data_t src_data;
    dotk_pkg::data_t coef_data;
    dotk_pkg::acc_t  sum_data;

    //////////////////////////////////////////////////
    // sequencer
    //////////////////////////////////////////////////
    exe_ctrl u_exe_ctrl (
        .clk(clk), .rst(rst), .s_init(s_init), .out_busy(out_busy), .out_fin(out_fin),
        .s_fin(s_fin), .k_init(k_init), .k_fin(k_fin), .exec(exec),
        .exec_src_addr(exec_src_addr)
    );

    //////////////////////////////////////////////////
    // buffers, sel picks the target of a host write
    //////////////////////////////////////////////////
    src_buff u_src_buff (
        .clk(clk), .we(ld_we & ~ld_sel), .waddr(ld_addr), .wdata(ld_data),
        .raddr(exec_src_addr), .rd_data(src_data)
    );

    coef_buff u_coef_buff (
        .clk(clk), .we(ld_we & ld_sel), .waddr(ld_addr), .wdata(ld_data),
        .raddr(exec_src_addr), .rd_data(coef_data)
    );

    //////////////////////////////////////////////////
    // datapath and output
    //////////////////////////////////////////////////
    mac_lane u_mac_lane (
        .clk(clk), .rst(rst), .k_init(k_init), .exec(exec), .k_fin(k_fin),
        .src_data(src_data), .coef_data(coef_data),
        .sum_valid(sum_valid), .sum_data(sum_data)
    );

    out_drain u_out_drain (
        .clk(clk), .rst(rst), .sum_valid(sum_valid), .sum_data(sum_data),
        .res_stall(res_stall), .res_valid(res_valid), .res_data(res_data),
        .out_busy(out_busy), .out_fin(out_fin)
    );

endmodule

`default_nettype wire

//--- tb/dotk_asserts.sv
`timescale 1ns/1ps

module dotk_asserts (
    input wire logic            clk,
    input wire logic            rst,
    input wire logic            s_init,
    input wire logic            res_valid,
    input wire logic            res_stall,
    input wire dotk_pkg::acc_t  res_data,
    input wire logic            s_fin
);

    // raised by any failing property, polled from the testbench
    bit   tripped = 1'b0;
    logic seen_init;
    logic run_open;

    // run bookkeeping for the properties below
    always_ff @(posedge clk) begin
        if (rst) begin
            seen_init <= 1'b0;
            run_open  <= 1'b0;
        end else if (s_init) begin
            seen_init <= 1'b1;
            run_open  <= 1'b1;
        end else if (s_fin) begin
            run_open  <= 1'b0;
        end
    end

    //////////////////////////////////////////////////
    // output protocol
    //////////////////////////////////////////////////

    // offered result frozen while stalled
    hold_under_stall: assert property (@(posedge clk) disable iff (rst)
        res_valid && res_stall |=> res_valid && $stable(res_data))
    else begin
        tripped = 1'b1;
        $error("res_valid dropped or res_data moved under res_stall");
    end

    // nothing comes out before the first run start
    quiet_before_init: assert property (@(posedge clk) disable iff (rst)
        !seen_init |-> !res_valid && !s_fin)
    else begin
        tripped = 1'b1;
        $error("res_valid or s_fin high before any s_init");
    end

    // end-of-run is a single-cycle pulse
    fin_single: assert property (@(posedge clk) disable iff (rst)
        s_fin |=> !s_fin)
    else begin
        tripped = 1'b1;
        $error("s_fin high two cycles in a row");
    end

    // a result only inside an open run
    result_in_run: assert property (@(posedge clk) disable iff (rst)
        $rose(res_valid) |-> run_open)
    else begin
        tripped = 1'b1;
        $error("res_valid rose outside a run");
    end

    // first block sum shows up soon after start
    first_result_prompt: assert property (@(posedge clk) disable iff (rst)
        s_init |-> ##[1:50] res_valid)
    else begin
        tripped = 1'b1;
        $error("no result within 50 cycles of s_init");
    end

endmodule

//--- tb/dotk_tb.sv
`timescale 1ns/1ps
`include "dotk_defines.svh"

module dotk_tb;

    localparam int RUNS       = 2;
    localparam int BLK_BUDGET = 200;
    // reset, both buffer loads, then the runs
    localparam int MAX_CYCLES = 3 + 2 * `MEM_DEPTH + RUNS * `K_ITER * BLK_BUDGET;

    logic            clk;
    logic            rst;
    logic            ld_we;
    logic            ld_sel;
    dotk_pkg::addr_t ld_addr;
    dotk_pkg::data_t ld_data;
    logic            s_init;
    logic            res_stall;
    logic            res_valid;
    dotk_pkg::acc_t  res_data;
    logic            s_fin;

    logic [31:0]     rng;
    // shadow copies of both buffers
    dotk_pkg::data_t src_sh [`MEM_DEPTH];
    dotk_pkg::data_t coef_sh [`MEM_DEPTH];
    dotk_pkg::acc_t  exp_q [$];
    dotk_pkg::acc_t  exp_sum;
    int              taken_in_run = 0;
    int              fin_cnt = 0;
    int              cyc_cnt = 0;

    dotk_top dut0 (
        .clk(clk), .rst(rst), .ld_we(ld_we), .ld_sel(ld_sel), .ld_addr(ld_addr),
        .ld_data(ld_data), .s_init(s_init), .res_stall(res_stall),
        .res_valid(res_valid), .res_data(res_data), .s_fin(s_fin)
    );

    bind dotk_top dotk_asserts chk0 (
        .clk(clk), .rst(rst), .s_init(s_init), .res_valid(res_valid),
        .res_stall(res_stall), .res_data(res_data), .s_fin(s_fin)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // reference sum for one block, by the addressing rule
    function automatic dotk_pkg::acc_t block_sum(input int blk);
        dotk_pkg::acc_t total;
        int             a;
        total = '0;
        for (int j = 0; j < `J_LEN; j++) begin
            a     = blk * `I_STRIDE + j;
            total = total + dotk_pkg::acc_t'(src_sh[a]) * dotk_pkg::acc_t'(coef_sh[a]);
        end
        return total;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string sig, input dotk_pkg::acc_t got,
                                   input dotk_pkg::acc_t want);
        abort_run($sformatf("[FAIL] %0t ns %s got 'h%0h expected 'h%0h",
                            $time, sig, got, want));
    endtask

    // host writes, one word per cycle, whole buffer
    task automatic fill_buffer(input logic sel);
        dotk_pkg::data_t word;
        for (int a = 0; a < `MEM_DEPTH; a++) begin
            rng  = lcg_next(rng);
            word = rng[31:16];
            if (sel) begin
                coef_sh[a] = word;
            end else begin
                src_sh[a] = word;
            end
            ld_we   <= 1'b1;
            ld_sel  <= sel;
            ld_addr <= dotk_pkg::addr_t'(a);
            ld_data <= word;
            @(posedge clk);
        end
        ld_we <= 1'b0;
    endtask

    // start pulse, then random back-pressure until s_fin
    task automatic run_once;
        s_init <= 1'b1;
        @(posedge clk);
        s_init <= 1'b0;
        do begin
            rng = lcg_next(rng);
            res_stall <= (rng[31:29] < 3'd3);
            @(posedge clk);
        end while (!s_fin);
        res_stall <= 1'b0;
    endtask

    //////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////
    initial begin
        rng       = 32'ha366;
        rst       = 1'b1;
        ld_we     = 1'b0;
        ld_sel    = 1'b0;
        ld_addr   = '0;
        ld_data   = '0;
        s_init    = 1'b0;
        res_stall = 1'b0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        fill_buffer(1'b0);
        fill_buffer(1'b1);
        @(posedge clk);
        // same buffer contents, so both runs expect the same sums
        for (int r = 0; r < RUNS; r++) begin
            for (int b = 0; b < `K_ITER; b++) begin
                exp_q.push_back(block_sum(b));
            end
            run_once();
        end
        repeat (4) @(posedge clk);
        if (exp_q.size() != 0 || fin_cnt != RUNS || dut0.chk0.tripped) begin
            abort_run($sformatf("end of test with %0d sums missing and %0d of %0d s_fin pulses",
                                exp_q.size(), fin_cnt, RUNS));
        end else begin
            $display("Simulation PASSED");
            $finish;
        end
    end

    //////////////////////////////////////////////////
    // result checks
    //////////////////////////////////////////////////
    always @(posedge clk) begin
        if (!rst) begin
            // result leaves in a cycle without stall
            if (res_valid && !res_stall) begin
                if (exp_q.size() == 0 || taken_in_run >= `K_ITER) begin
                    abort_run($sformatf("result taken at %0t ns beyond the blocks of the run",
                                        $time));
                end else begin
                    exp_sum = exp_q.pop_front();
                    if (res_data !== exp_sum) begin
                        report_mismatch("res_data", res_data, exp_sum);
                    end else begin
                        taken_in_run++;
                    end
                end
            end
            if (s_fin) begin
                if (taken_in_run != `K_ITER) begin
                    abort_run($sformatf("s_fin at %0t ns after only %0d results",
                                        $time, taken_in_run));
                end else begin
                    fin_cnt++;
                    taken_in_run = 0;
                end
            end
        end
    end

    // watchdog and assertion flag
    always @(posedge clk) begin
        cyc_cnt++;
        if (cyc_cnt >= MAX_CYCLES) begin
            abort_run($sformatf("timeout after %0d cycles before both runs ended", cyc_cnt));
        end else if (dut0.chk0.tripped) begin
            abort_run("a protocol assertion in dotk_asserts failed");
        end
    end

endmodule

//--- list.f
+incdir+common
common/dotk_pkg.sv
exe/agu_next.sv
exe/exe_ctrl.sv
logic/src_buff.sv
logic/coef_buff.sv
logic/mac_lane.sv
logic/out_drain.sv
logic/dotk_top.sv
tb/dotk_asserts.sv
tb/dotk_tb.sv
